// ==== logic/rv32_settings.svh ====
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// PC loaded by reset.
`define RV32_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0.
`define RV32_INSTR_NOP 32'h0000_0013

// Program memory depth in 32-bit words.
`define RV32_MEM_WORDS 256

`endif

// ==== logic/rv32_pkg.sv ====
package rv32_pkg;

    // ########################################################################
    // RV32I major opcodes (instr[6:0])
    // ########################################################################
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Master that held the memory port in the last granted cycle.
    typedef enum logic {
        OWNER_FETCH  = 1'b0,
        OWNER_LOADER = 1'b1
    } mem_owner_e;

    // APB loader transfer phase.
    typedef enum logic [1:0] {
        APB_IDLE = 2'b00,  // Waiting for a setup cycle.
        APB_WAIT = 2'b01,  // Request pending, no grant yet.
        APB_DONE = 2'b10   // Completion cycle, pready high.
    } apb_phase_e;

endpackage

// ==== logic/rv32_fetch.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_fetch (
    input  logic        clk,
    input  logic        reset_,
    input  logic        stall,
    input  logic        branch_mispredicted,
    input  logic [31:0] branch_pc,
    input  logic        fetch_grant,
    input  logic [31:0] fetch_rdata,
    output logic [31:0] fetch_addr,
    output logic [31:0] pc_out,
    output logic [31:0] instr_out,
    output logic        valid_out,
    output logic        branch_predicted_taken_out
);
    import rv32_pkg::*;

    logic [31:0] next_pc;
    logic [31:0] pc;

    opcode_e     opcode;
    logic        sign;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        predict_taken;
    logic [31:0] pc_offset;

    // ########################################################################
    // Current fetch address
    // ########################################################################
    assign pc         = branch_mispredicted ? branch_pc : next_pc;  // Redirect wins.
    assign fetch_addr = pc;

    // ########################################################################
    // Static predictor on the word being read this cycle
    // ########################################################################
    assign opcode = opcode_e'(fetch_rdata[6:0]);
    assign sign   = fetch_rdata[31];

    // J-type immediate.
    assign imm_j = {{12{sign}}, fetch_rdata[19:12], fetch_rdata[20],
                    fetch_rdata[30:21], 1'b0};
    // B-type immediate.
    assign imm_b = {{20{sign}}, fetch_rdata[7], fetch_rdata[30:25],
                    fetch_rdata[11:8], 1'b0};

    always_comb begin
        predict_taken = 1'b0;
        pc_offset     = 32'd4;
        case (opcode)
            OP_JAL: begin
                predict_taken = 1'b1;             // Always taken.
                pc_offset     = imm_j;
            end
            OP_BRANCH: begin
                if (sign) begin                   // Backward branch, loop guess.
                    predict_taken = 1'b1;
                    pc_offset     = imm_b;
                end
            end
            default: begin
            end
        endcase
    end

    // ########################################################################
    // PC and output registers
    // ########################################################################
    always_ff @(posedge clk) begin
        if (!reset_) begin
            next_pc                    <= `RV32_RESET_PC;
            pc_out                     <= `RV32_RESET_PC;
            instr_out                  <= `RV32_INSTR_NOP;
            valid_out                  <= 1'b0;
            branch_predicted_taken_out <= 1'b0;
        end else if (stall) begin
            next_pc <= pc;                            // Keep a redirect seen while held.
        end else if (fetch_grant) begin
            next_pc                    <= pc + pc_offset;
            pc_out                     <= pc;
            instr_out                  <= fetch_rdata;
            valid_out                  <= 1'b1;
            branch_predicted_taken_out <= predict_taken;
        end else begin
            next_pc                    <= pc;         // Lost the port, retry.
            valid_out                  <= 1'b0;       // Bubble.
            branch_predicted_taken_out <= 1'b0;
        end
    end

    // A taken prediction always travels with a valid instruction.
    assert property (@(posedge clk) disable iff (!reset_)
        branch_predicted_taken_out |-> valid_out);

endmodule

// ==== logic/rv32_mem_arbiter.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_mem_arbiter (
    input  logic                               clk,
    input  logic                               reset_,
    // Fetch master requests every cycle.
    input  logic [31:0]                        fetch_addr,
    output logic                               fetch_grant,
    output logic [31:0]                        fetch_rdata,
    // Loader master.
    input  logic                               load_req,
    input  logic                               load_write,
    input  logic [31:0]                        load_addr,
    input  logic [31:0]                        load_wdata,
    output logic                               load_grant,
    output logic [31:0]                        load_rdata,
    // Memory port.
    output logic [$clog2(`RV32_MEM_WORDS)-1:0] mem_addr,
    output logic                               mem_write,
    output logic [31:0]                        mem_wdata,
    input  logic [31:0]                        mem_rdata
);
    import rv32_pkg::*;

    localparam int ADDR_W = $clog2(`RV32_MEM_WORDS);

    mem_owner_e last_owner;

    // ########################################################################
    // Grant selection
    // ########################################################################
    // Fetch always asks, so the loader only wins after a fetch-owned cycle.
    assign load_grant  = load_req && (last_owner == OWNER_FETCH);
    assign fetch_grant = !load_grant;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            last_owner <= OWNER_FETCH;
        end else begin
            last_owner <= load_grant ? OWNER_LOADER : OWNER_FETCH;
        end
    end

    // ########################################################################
    // Memory port steering
    // ########################################################################
    assign mem_addr  = load_grant ? load_addr[2 +: ADDR_W]
                                  : fetch_addr[2 +: ADDR_W];  // Byte to word index.
    assign mem_write = load_grant && load_write;
    assign mem_wdata = load_wdata;

    // Read data is shared; each master qualifies it with its grant.
    assign fetch_rdata = mem_rdata;
    assign load_rdata  = mem_rdata;

    assert property (@(posedge clk) disable iff (!reset_)
        !(fetch_grant && load_grant));

    // A write only reaches memory for a pending loader request.
    assert property (@(posedge clk) disable iff (!reset_)
        mem_write |-> (load_grant && load_req && load_write));

endmodule

// ==== logic/rv32_memory.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_memory (
    input  logic                               clk,
    input  logic                               write,
    input  logic [$clog2(`RV32_MEM_WORDS)-1:0] addr,
    input  logic [31:0]                        wdata,
    output logic [31:0]                        rdata
);

    // ########################################################################
    // Program storage
    // ########################################################################
    logic [31:0] mem [`RV32_MEM_WORDS];   // Contents set by the loader.

    assign rdata = mem[addr];             // Same-cycle read.

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;           // Commits at the edge.
        end
    end

endmodule

// ==== logic/rv32_apb_loader.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_apb_loader (
    input  logic        clk,
    input  logic        reset_,
    // APB slave.
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    // Memory request toward the arbiter.
    output logic        load_req,
    output logic        load_write,
    output logic [31:0] load_addr,
    output logic [31:0] load_wdata,
    input  logic        load_grant,
    input  logic [31:0] load_rdata
);
    import rv32_pkg::*;

    apb_phase_e phase;
    logic       setup;
    logic       in_range;
    logic       err_q;

    assign setup    = psel && !penable;
    assign in_range = paddr[31:2] < 30'(`RV32_MEM_WORDS);

    // ########################################################################
    // Request side
    // ########################################################################
    // The host holds address and data for the whole transfer.
    assign load_req   = (phase == APB_WAIT) || (phase == APB_IDLE && setup && in_range);
    assign load_write = pwrite;
    assign load_addr  = paddr;
    assign load_wdata = pwdata;

    assign pready  = (phase == APB_DONE);
    assign pslverr = (phase == APB_DONE) && err_q;

    // ########################################################################
    // Transfer FSM
    // ########################################################################
    always_ff @(posedge clk) begin
        if (!reset_) begin
            phase <= APB_IDLE;
            err_q <= 1'b0;
        end else begin
            case (phase)
                APB_IDLE: begin
                    if (setup) begin
                        err_q <= !in_range;
                        if (!in_range || load_grant) begin
                            phase <= APB_DONE;    // Finish in first access cycle.
                        end else begin
                            phase <= APB_WAIT;
                        end
                    end
                end
                APB_WAIT: begin
                    if (load_grant) begin
                        phase <= APB_DONE;
                    end
                end
                default: begin
                    phase <= APB_IDLE;            // Transfer ends with pready.
                end
            endcase
        end
    end

    // Read data is taken in the grant cycle.
    always_ff @(posedge clk) begin
        if (load_grant && !pwrite) begin
            prdata <= load_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_)
        pready |-> (psel && penable));

endmodule

// ==== logic/rv32_frontend_top.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_frontend_top (
    input  logic        clk,
    input  logic        reset_,
    // Pipeline control.
    input  logic        stall,
    input  logic        branch_mispredicted,
    input  logic [31:0] branch_pc,
    // APB slave.
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    // Fetch output.
    output logic [31:0] pc_out,
    output logic [31:0] instr_out,
    output logic        valid_out,
    output logic        branch_predicted_taken_out
);

    logic [31:0]                        fetch_addr;
    logic                               fetch_grant;
    logic [31:0]                        fetch_rdata;
    logic                               load_req;
    logic                               load_write;
    logic [31:0]                        load_addr;
    logic [31:0]                        load_wdata;
    logic                               load_grant;
    logic [31:0]                        load_rdata;
    logic [$clog2(`RV32_MEM_WORDS)-1:0] mem_addr;
    logic                               mem_write;
    logic [31:0]                        mem_wdata;
    logic [31:0]                        mem_rdata;

    rv32_fetch u_fetch (
        .clk, .reset_, .stall, .branch_mispredicted, .branch_pc,
        .fetch_grant, .fetch_rdata, .fetch_addr,
        .pc_out, .instr_out, .valid_out, .branch_predicted_taken_out
    );

    rv32_apb_loader u_loader (
        .clk, .reset_, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .prdata, .pslverr,
        .load_req, .load_write, .load_addr, .load_wdata, .load_grant, .load_rdata
    );

    rv32_mem_arbiter u_arbiter (
        .clk, .reset_,
        .fetch_addr, .fetch_grant, .fetch_rdata,
        .load_req, .load_write, .load_addr, .load_wdata, .load_grant, .load_rdata,
        .mem_addr, .mem_write, .mem_wdata, .mem_rdata
    );

    rv32_memory u_memory (
        .clk, .write(mem_write), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset_
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset held for 5 rising edges, released just after an edge.
    initial begin
        reset_ = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset_ = 1'b1;
    end

endmodule

// ==== sim/rv32_frontend_tb.sv ====
`timescale 1ns/100ps
`include "rv32_settings.svh"

module rv32_frontend_tb;
    import rv32_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // Loads plus runs take well under half of this.
    localparam int APB_MAX_WAIT   = 1;      // One extra access cycle for a lost grant.

    logic        clk;
    logic        reset_;
    logic        stall;
    logic        branch_mispredicted;
    logic [31:0] branch_pc;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic [31:0] pc_out;
    logic [31:0] instr_out;
    logic        valid_out;
    logic        branch_predicted_taken_out;

    logic [31:0] shadow [`RV32_MEM_WORDS];  // Host view of program memory.
    logic [31:0] exp_pc;
    int          checked_count;
    int          cycle_count;
    integer      seed;

    tb_clock u_clock (.clk(clk), .reset_(reset_));

    rv32_frontend_top UUT (
        .clk, .reset_, .stall, .branch_mispredicted, .branch_pc,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pready, .prdata, .pslverr,
        .pc_out, .instr_out, .valid_out, .branch_predicted_taken_out
    );

    // ########################################################################
    // Check, reference model and instruction encoders
    // ########################################################################
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // JAL and backward branches are taken and all else falls through by 4.
    function automatic void predict_next(input logic [31:0] pc, input logic [31:0] instr,
                                         output logic taken, output logic [31:0] next_pc);
        opcode_e     op;
        logic [20:0] j_off;
        logic [12:0] b_off;
        op      = opcode_e'(instr[6:0]);
        j_off   = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        b_off   = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        taken   = 1'b0;
        next_pc = pc + 32'd4;
        if (op == OP_JAL) begin
            taken   = 1'b1;
            next_pc = pc + {{11{j_off[20]}}, j_off};
        end else if (op == OP_BRANCH && b_off[12]) begin
            taken   = 1'b1;
            next_pc = pc + {{19{b_off[12]}}, b_off};
        end
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, OP_JAL};
    endfunction

    function automatic logic [31:0] enc_branch(input int off, input logic [2:0] f3);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, f3, o[4:1], o[11], OP_BRANCH};
    endfunction

    // ########################################################################
    // Compare process
    // ########################################################################
    always @(posedge clk) begin : compare
        logic        edge_rst;
        logic        edge_stall;
        logic        edge_redirect;
        logic [31:0] edge_bpc;
        logic        exp_taken;
        logic [31:0] nxt_pc;
        logic [31:0] prev_pc;
        logic [31:0] prev_instr;
        logic        prev_valid;
        logic        prev_taken;
        edge_rst      = reset_;
        edge_stall    = stall;
        edge_redirect = branch_mispredicted;
        edge_bpc      = branch_pc;
        @(negedge clk);
        if (edge_rst && edge_stall) begin   // Held outputs.
            check("stall hold pc_out", prev_pc, pc_out);
            check("stall hold instr_out", prev_instr, instr_out);
            check("stall hold valid_out", {31'd0, prev_valid}, {31'd0, valid_out});
            check("stall hold taken", {31'd0, prev_taken}, {31'd0, branch_predicted_taken_out});
        end
        if (edge_rst && edge_redirect) begin
            exp_pc = edge_bpc;
        end
        if (edge_rst && !edge_stall && valid_out) begin
            predict_next(exp_pc, shadow[exp_pc[9:2]], exp_taken, nxt_pc);
            check("fetch pc_out", exp_pc, pc_out);
            check("fetch instr_out", shadow[exp_pc[9:2]], instr_out);
            check("fetch taken", {31'd0, exp_taken}, {31'd0, branch_predicted_taken_out});
            exp_pc = nxt_pc;
            checked_count++;
        end
        prev_pc    = pc_out;
        prev_instr = instr_out;
        prev_valid = valid_out;
        prev_taken = branch_predicted_taken_out;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    // ########################################################################
    // Stimulus helpers
    // ########################################################################
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Waits in the access phase until pready is seen at a falling edge.
    task automatic wait_ready(output logic err, output logic [31:0] data);
        int waits;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > APB_MAX_WAIT) begin
                $display("APB transfer to %h was not ready by the second access cycle", paddr);
                $display("Some tests failed");
                $fatal(1, "APB timeout");
            end
            @(negedge clk);
        end
        err  = pslverr;
        data = prdata;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        wait_ready(err, unused);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        wait_ready(err, data);
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("load pslverr", 32'd0, {31'd0, err});
        shadow[addr[9:2]] = data;
    endtask

    // Redirects the fetch to pc and releases the stall in the same cycle.
    task automatic start_at(input logic [31:0] pc);
        stall               = 1'b0;
        branch_mispredicted = 1'b1;
        branch_pc           = pc;
        next_cycle();
        branch_mispredicted = 1'b0;
    endtask

    task automatic run_outputs(input int n);
        int target;
        target = checked_count + n;
        while (checked_count < target) begin
            @(posedge clk);
        end
        #1;
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################
    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic        err;
        int          idx;
        seed                = 32'h1d0c34cb;
        checked_count       = 0;
        cycle_count         = 0;
        exp_pc              = `RV32_RESET_PC;
        stall               = 1'b1;
        branch_mispredicted = 1'b0;
        branch_pc           = 32'd0;
        psel                = 1'b0;
        penable             = 1'b0;
        pwrite              = 1'b0;
        paddr               = 32'd0;
        pwdata              = 32'd0;

        @(posedge reset_);
        @(negedge clk);
        check("reset valid_out", 32'd0, {31'd0, valid_out});
        check("reset taken", 32'd0, {31'd0, branch_predicted_taken_out});
        check("reset instr_out", `RV32_INSTR_NOP, instr_out);
        check("reset pc_out", `RV32_RESET_PC, pc_out);
        next_cycle();

        // Random writes and readbacks while fetch keeps requesting.
        repeat (16) begin
            addr = 32'h300 + (({$random(seed)} % 64) * 4);
            data = $random(seed);
            load_word(addr, data);
            apb_read(addr, rdata, err);
            check("readback pslverr", 32'd0, {31'd0, err});
            check("readback data", data, rdata);
        end
        apb_write(32'h400, 32'hdead_beef, err);
        check("out of range write pslverr", 32'd1, {31'd0, err});
        apb_read(32'h0000_1000, rdata, err);
        check("out of range read pslverr", 32'd1, {31'd0, err});

        // Straight-line ALU program ending in a self loop.
        for (int i = 0; i < 15; i++) begin
            load_word(32'h100 + i * 4, enc_addi(12'(i + 1)));
        end
        load_word(32'h13c, enc_jal(0));
        start_at(32'h100);
        run_outputs(20);

        // Mispredict redirects into the same program.
        repeat (4) begin
            idx = {$random(seed)} % 16;
            branch_mispredicted = 1'b1;
            branch_pc           = 32'h100 + 32'(idx * 4);
            next_cycle();
            branch_mispredicted = 1'b0;
            run_outputs(6);
        end

        // Mixed control flow loaded while the fetch is held.
        stall = 1'b1;
        next_cycle();
        load_word(32'h200, enc_addi(12'h7));
        load_word(32'h204, enc_branch(8, 3'b000));      // Forward branch falls through.
        load_word(32'h208, {12'd0, 5'd1, 3'b000, 5'd0, OP_JALR});
        load_word(32'h20c, enc_jal(12));
        load_word(32'h210, enc_addi(12'h1));
        load_word(32'h214, enc_addi(12'h2));
        load_word(32'h218, enc_addi(12'h3));
        load_word(32'h21c, enc_branch(-8, 3'b001));     // Backward loop.
        start_at(32'h200);
        run_outputs(16);

        // Random stall cycles on the running loop.
        repeat (40) begin
            stall = 1'($random(seed));
            next_cycle();
        end
        stall = 1'b0;
        run_outputs(8);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/rv32_pkg.sv
logic/rv32_fetch.sv
logic/rv32_mem_arbiter.sv
logic/rv32_memory.sv
logic/rv32_apb_loader.sv
logic/rv32_frontend_top.sv
sim/tb_clock.sv
sim/rv32_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module rv32_frontend_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrv32_frontend_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
